/* mips_stimulus.txt */
# I word-index instruction | D byte-address data-word | S store-address store-data
# S lines are in program order
I 00 3c011234
I 01 34215678
I 02 ac010000
I 03 2402fffb
I 04 00221821
I 05 00412023
I 06 ac030004
I 07 ac040008
I 08 00232824
I 09 00233025
I 0a 00233826
I 0b 00234027
I 0c 0041482a
I 0d 0041502b
I 0e ac05000c
I 0f ac060010
I 10 ac070014
I 11 ac080018
I 12 ac09001c
I 13 ac0a0020
I 14 00015900
I 15 00026043
I 16 00046a02
I 17 ac0b0024
I 18 ac0c0028
I 19 ac0d002c
I 1a 302ef0f0
I 1b 384f8000
I 1c 2850fffc
I 1d ac0e0030
I 1e ac0f0034
I 1f ac100038
I 20 8c110040
I 21 26320003
I 22 ac12003c
I 23 8c130044
I 24 16600002
I 25 26740001
I 26 24140063
I 27 ac140048
I 28 24150005
I 29 12a00001
I 2a 26b50001
I 2b ac15004c
I 2c 0ff0002f
I 2d 24160011
I 2e 24160099
I 2f ac1f0050
I 30 3c17bfc0
I 31 36f700d4
I 32 02e00008
I 33 ac160054
I 34 ac00005c
I 35 ac170058
I 36 0bf00039
I 37 ac010060
I 38 ac000064
I 39 0bf00039
I 3a 00000000
D 40 cafe0001
D 44 00000007
S 00 12345678
S 04 12345673
S 08 edcba983
S 0c 12345670
S 10 1234567b
S 14 0000000b
S 18 edcba984
S 1c 00000001
S 20 00000000
S 24 23456780
S 28 fffffffd
S 2c 00edcba9
S 30 00005070
S 34 ffff7ffb
S 38 00000001
S 3c cafe0004
S 48 00000008
S 4c 00000006
S 50 bfc000b8
S 54 00000011
S 58 bfc000d4
S 60 12345678

/* files.f */
cpu_pkg.sv
control_unit.sv
reg_file.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
hazard_unit.sv
mips_core.sv
tb_mips_core.sv

/* Bender.yml */
package:
  name: mips_core

sources:
  - cpu_pkg.sv
  - control_unit.sv
  - reg_file.sv
  - fetch_stage.sv
  - decode_stage.sv
  - execute_stage.sv
  - memory_stage.sv
  - hazard_unit.sv
  - mips_core.sv
  - target: test
    files:
      - tb_mips_core.sv

/* tb_mips_core.sv */
`timescale 1ns/1ps

module tb_mips_core;

    logic        clk;
    logic        resetn;
    logic        inst_req;
    logic [31:0] inst_addr;
    logic [31:0] inst_rdata;
    logic        inst_ok;
    logic        data_req;
    logic        data_wr;
    logic [31:0] data_addr;
    logic [31:0] data_wdata;
    logic [3:0]  data_strobe;
    logic [31:0] data_rdata;
    logic        data_ok;

    logic [31:0] imem [0:63];
    logic [31:0] dmem [0:63];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic [15:0] lfsr;
    int          prog_lines;
    int          cycle;
    int          limit;
    int          inst_delay;
    int          data_delay;
    bit          first_fetch_seen;

    mips_core i_dut (
        .clk        (clk),
        .resetn     (resetn),
        .inst_req   (inst_req),
        .inst_addr  (inst_addr),
        .inst_rdata (inst_rdata),
        .inst_ok    (inst_ok),
        .data_req   (data_req),
        .data_wr    (data_wr),
        .data_addr  (data_addr),
        .data_wdata (data_wdata),
        .data_strobe(data_strobe),
        .data_rdata (data_rdata),
        .data_ok    (data_ok)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // fibonacci lfsr, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic draw_delay(output int d);
        logic [1:0] bits;
        lfsr    = lfsr_next(lfsr);
        bits[0] = lfsr[0];
        lfsr    = lfsr_next(lfsr);
        bits[1] = lfsr[0];
        d       = bits;
    endtask

    task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s, got %h, expected %h", $time, what, got, exp);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic load_stimulus();
        int          fd;
        int          n;
        string       line;
        logic [7:0]  tag;
        logic [31:0] a;
        logic [31:0] v;
        fd = $fopen("mips_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file mips_stimulus.txt");
            $display("Simulation failed");
            $fatal(1);
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (line.len() > 2 && line.getc(0) != "#") begin
                n = $sscanf(line, "%c %h %h", tag, a, v);
                if (tag == "I") begin
                    imem[a[5:0]] = v;
                    prog_lines++;
                end else if (tag == "D") begin
                    dmem[a[7:2]] = v;
                end else if (tag == "S") begin
                    exp_addr.push_back(a);
                    exp_data.push_back(v);
                end
            end
        end
        $fclose(fd);
    endtask

    // bus models, both share one lfsr
    always @(posedge clk) begin
        if (!resetn) begin
            inst_ok <= 1'b0;
            data_ok <= 1'b0;
            if (cycle > 1) begin
                check_equal({31'b0, inst_req}, 32'd0, "inst_req during reset");
                check_equal({31'b0, data_req}, 32'd0, "data_req during reset");
            end
        end else begin
            if (inst_req && !first_fetch_seen) begin
                check_equal(inst_addr, 32'hbfc0_0000, "first fetch address");
                first_fetch_seen = 1'b1;
            end
            if (inst_ok) begin
                inst_ok <= 1'b0;
            end else if (inst_req) begin
                if (inst_delay == 0) begin
                    check_equal({inst_addr[31:8], 8'h00}, 32'hbfc0_0000, "fetch range");
                    inst_rdata <= imem[inst_addr[7:2]];
                    inst_ok    <= 1'b1;
                    draw_delay(inst_delay);
                end else begin
                    inst_delay = inst_delay - 1;
                end
            end
            if (data_ok) begin
                data_ok <= 1'b0;
            end else if (data_req) begin
                if (data_delay == 0) begin
                    check_equal({data_addr[31:8], 8'h00}, 32'd0, "data address range");
                    if (data_wr) begin
                        if (exp_addr.size() == 0) begin
                            $display("a store to %h appeared after the last expected one",
                                     data_addr);
                            $display("Simulation failed");
                            $fatal(1);
                        end
                        check_equal({28'b0, data_strobe}, 32'hf, "store strobe");
                        check_equal(data_addr, exp_addr.pop_front(), "store address");
                        check_equal(data_wdata, exp_data.pop_front(), "store data");
                        dmem[data_addr[7:2]] = data_wdata;
                    end else begin
                        check_equal({28'b0, data_strobe}, 32'h0, "load strobe");
                        data_rdata <= dmem[data_addr[7:2]];
                    end
                    data_ok <= 1'b1;
                    draw_delay(data_delay);
                end else begin
                    data_delay = data_delay - 1;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (limit > 0 && cycle >= limit) begin
            $display("timeout after %0d cycles with %0d stores still missing",
                     cycle, exp_addr.size());
            $display("Simulation failed");
            $fatal(1);
        end
    end

    initial begin
        resetn     = 1'b0;
        inst_rdata = '0;
        inst_ok    = 1'b0;
        data_rdata = '0;
        data_ok    = 1'b0;
        cycle      = 0;
        limit      = 0;
        prog_lines = 0;
        lfsr       = 16'd9495;
        first_fetch_seen = 1'b0;
        for (int i = 0; i < 64; i++) begin
            // unloaded words are sw $zero to their own address
            imem[i] = 32'hac00_0000 | (i << 2);
            dmem[i] = 32'hd00d_0000 | (i << 2);
        end
        load_stimulus();
        limit = 100 + 8 * prog_lines * 4;
        draw_delay(inst_delay);
        draw_delay(data_delay);
        repeat (16) @(posedge clk);
        resetn <= 1'b1;
        while (exp_addr.size() != 0) begin
            @(posedge clk);
        end
        // quiet period on the final self-loop
        repeat (50) @(posedge clk);
        $display("Simulation passed");
        $finish;
    end

endmodule

/* mips_core.sv */
`timescale 1ns/1ps

module mips_core (
    input  logic           clk,
    input  logic           resetn,
    output logic           inst_req,
    output cpu_pkg::word_t inst_addr,
    input  cpu_pkg::word_t inst_rdata,
    input  logic           inst_ok,
    output logic           data_req,
    output logic           data_wr,
    output cpu_pkg::word_t data_addr,
    output cpu_pkg::word_t data_wdata,
    output logic [3:0]     data_strobe,
    input  cpu_pkg::word_t data_rdata,
    input  logic           data_ok
);
    cpu_pkg::word_t    instr;
    cpu_pkg::word_t    pc_plus4;
    logic              fetch_wait;
    logic              branch_taken;
    cpu_pkg::word_t    branch_target;

    cpu_pkg::reg_idx_t rs;
    cpu_pkg::reg_idx_t rt;
    logic              rs_used;
    logic              rt_used;
    cpu_pkg::fwd_sel_t fwd_a;
    cpu_pkg::fwd_sel_t fwd_b;

    // ID/EX
    cpu_pkg::alu_op_t  alu_op;
    cpu_pkg::word_t    op_a;
    cpu_pkg::word_t    op_b;
    logic [4:0]        shamt;
    cpu_pkg::word_t    store_data;
    cpu_pkg::reg_idx_t dst;
    cpu_pkg::wb_src_t  wb_src;
    logic              mem_wr;

    // EX/MEM
    cpu_pkg::word_t    ex_result;
    cpu_pkg::word_t    alu_result;
    cpu_pkg::word_t    store_data_m;
    cpu_pkg::reg_idx_t dst_m;
    cpu_pkg::wb_src_t  wb_src_m;
    logic              mem_wr_m;
    cpu_pkg::reg_idx_t e_dst;
    logic              e_load;

    cpu_pkg::word_t    mem_result;
    cpu_pkg::reg_idx_t m_dst;
    logic              m_load;
    logic              mem_wait;
    cpu_pkg::reg_idx_t wb_dst;
    cpu_pkg::word_t    wb_data;

    logic              pipe_stall;
    logic              load_stall;

    fetch_stage   u_fetch   (.*);
    decode_stage  u_decode  (.*);
    execute_stage u_execute (.*);
    memory_stage  u_memory  (.*);
    hazard_unit   u_hazard  (.*);

endmodule

/* hazard_unit.sv */
`timescale 1ns/1ps

module hazard_unit (
    input  logic              clk,
    input  logic              resetn,
    input  cpu_pkg::reg_idx_t rs,
    input  cpu_pkg::reg_idx_t rt,
    input  logic              rs_used,
    input  logic              rt_used,
    input  cpu_pkg::reg_idx_t e_dst,
    input  logic              e_load,
    input  cpu_pkg::reg_idx_t m_dst,
    input  logic              m_load,
    input  cpu_pkg::reg_idx_t wb_dst,
    input  logic              fetch_wait,
    input  logic              mem_wait,
    output cpu_pkg::fwd_sel_t fwd_a,
    output cpu_pkg::fwd_sel_t fwd_b,
    output logic              pipe_stall,
    output logic              load_stall
);
    // youngest writer wins
    function automatic cpu_pkg::fwd_sel_t pick(input cpu_pkg::reg_idx_t src, input logic used);
        if (!used || src == '0) begin
            return cpu_pkg::fwd_rf;
        end else if (src == e_dst) begin
            return e_load ? cpu_pkg::fwd_rf : cpu_pkg::fwd_ex;
        end else if (src == m_dst) begin
            return cpu_pkg::fwd_mem;
        end else if (src == wb_dst) begin
            return cpu_pkg::fwd_wb;
        end
        return cpu_pkg::fwd_rf;
    endfunction

    function automatic logic load_hit(input cpu_pkg::reg_idx_t src, input logic used);
        return used && src != '0 && ((e_load && src == e_dst) || (m_load && src == m_dst));
    endfunction

    always_comb begin
        fwd_a      = pick(rs, rs_used);
        fwd_b      = pick(rt, rt_used);
        load_stall = load_hit(rs, rs_used) | load_hit(rt, rt_used);
        pipe_stall = fetch_wait | mem_wait;
    end

    // the bubble from decode must reach execute
    assert property (@(posedge clk) disable iff (!resetn)
        load_stall && !pipe_stall |=> !e_load);

endmodule

/* memory_stage.sv */
`timescale 1ns/1ps

module memory_stage (
    input  logic              clk,
    input  logic              resetn,
    input  cpu_pkg::word_t    alu_result,
    input  cpu_pkg::word_t    store_data_m,
    input  cpu_pkg::reg_idx_t dst_m,
    input  cpu_pkg::wb_src_t  wb_src_m,
    input  logic              mem_wr_m,
    input  cpu_pkg::word_t    data_rdata,
    input  logic              data_ok,
    input  logic              pipe_stall,
    output logic              data_req,
    output logic              data_wr,
    output cpu_pkg::word_t    data_addr,
    output cpu_pkg::word_t    data_wdata,
    output logic [3:0]        data_strobe,
    output cpu_pkg::word_t    mem_result,
    output cpu_pkg::reg_idx_t m_dst,
    output logic              m_load,
    output logic              mem_wait,
    output cpu_pkg::reg_idx_t wb_dst,
    output cpu_pkg::word_t    wb_data
);
    logic           done;
    cpu_pkg::word_t rdata_hold;
    cpu_pkg::word_t load_data;

    assign m_dst       = dst_m;
    assign m_load      = (wb_src_m == cpu_pkg::wb_mem);
    assign mem_result  = alu_result;
    assign data_req    = (mem_wr_m | m_load) & ~done;
    assign data_wr     = mem_wr_m;
    assign data_addr   = alu_result;
    assign data_wdata  = store_data_m;
    assign data_strobe = {4{mem_wr_m}};
    assign mem_wait    = data_req & ~data_ok;
    assign load_data   = done ? rdata_hold : data_rdata;

    // access finished but fetch still holds the pipe
    always_ff @(posedge clk) begin
        if (!resetn) begin
            done <= 1'b0;
        end else begin
            done <= pipe_stall & (done | (data_req & data_ok));
        end
    end

    always_ff @(posedge clk) begin
        if (data_req && data_ok) begin
            rdata_hold <= data_rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn || pipe_stall) begin
            wb_dst <= '0;
        end else begin
            wb_dst <= m_dst;
        end
    end

    always_ff @(posedge clk) begin
        if (!pipe_stall) begin
            wb_data <= m_load ? load_data : alu_result;
        end
    end

    assert property (@(posedge clk) disable iff (!resetn)
        data_req |-> data_addr[1:0] == 2'b00);

endmodule

/* execute_stage.sv */
`timescale 1ns/1ps

module execute_stage (
    input  logic              clk,
    input  logic              resetn,
    input  cpu_pkg::alu_op_t  alu_op,
    input  cpu_pkg::word_t    op_a,
    input  cpu_pkg::word_t    op_b,
    input  logic [4:0]        shamt,
    input  cpu_pkg::word_t    store_data,
    input  cpu_pkg::reg_idx_t dst,
    input  cpu_pkg::wb_src_t  wb_src,
    input  logic              mem_wr,
    input  logic              pipe_stall,
    output cpu_pkg::word_t    ex_result,
    output cpu_pkg::word_t    alu_result,
    output cpu_pkg::word_t    store_data_m,
    output cpu_pkg::reg_idx_t dst_m,
    output cpu_pkg::wb_src_t  wb_src_m,
    output logic              mem_wr_m,
    output cpu_pkg::reg_idx_t e_dst,
    output logic              e_load
);
    assign e_dst  = dst;
    assign e_load = (wb_src == cpu_pkg::wb_mem);

    always_comb begin
        case (alu_op)
            cpu_pkg::alu_add:  ex_result = op_a + op_b;
            cpu_pkg::alu_sub:  ex_result = op_a - op_b;
            cpu_pkg::alu_and:  ex_result = op_a & op_b;
            cpu_pkg::alu_or:   ex_result = op_a | op_b;
            cpu_pkg::alu_xor:  ex_result = op_a ^ op_b;
            cpu_pkg::alu_nor:  ex_result = ~(op_a | op_b);
            cpu_pkg::alu_slt:  ex_result = {31'b0, $signed(op_a) < $signed(op_b)};
            cpu_pkg::alu_sltu: ex_result = {31'b0, op_a < op_b};
            // shifts take rt through op_b
            cpu_pkg::alu_sll:  ex_result = op_b << shamt;
            cpu_pkg::alu_srl:  ex_result = op_b >> shamt;
            cpu_pkg::alu_sra:  ex_result = $signed(op_b) >>> shamt;
            cpu_pkg::alu_lui:  ex_result = op_b;
            default:           ex_result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            dst_m    <= '0;
            wb_src_m <= cpu_pkg::wb_alu;
            mem_wr_m <= 1'b0;
        end else if (!pipe_stall) begin
            dst_m    <= dst;
            wb_src_m <= wb_src;
            mem_wr_m <= mem_wr;
        end
    end

    always_ff @(posedge clk) begin
        if (!pipe_stall) begin
            alu_result   <= ex_result;
            store_data_m <= store_data;
        end
    end

endmodule

/* decode_stage.sv */
`timescale 1ns/1ps

module decode_stage (
    input  logic              clk,
    input  logic              resetn,
    input  cpu_pkg::word_t    instr,
    input  cpu_pkg::word_t    pc_plus4,
    input  cpu_pkg::fwd_sel_t fwd_a,
    input  cpu_pkg::fwd_sel_t fwd_b,
    input  cpu_pkg::word_t    ex_result,
    input  cpu_pkg::word_t    mem_result,
    input  cpu_pkg::reg_idx_t wb_dst,
    input  cpu_pkg::word_t    wb_data,
    input  logic              pipe_stall,
    input  logic              load_stall,
    output cpu_pkg::reg_idx_t rs,
    output cpu_pkg::reg_idx_t rt,
    output logic              rs_used,
    output logic              rt_used,
    output logic              branch_taken,
    output cpu_pkg::word_t    branch_target,
    output cpu_pkg::alu_op_t  alu_op,
    output cpu_pkg::word_t    op_a,
    output cpu_pkg::word_t    op_b,
    output logic [4:0]        shamt,
    output cpu_pkg::word_t    store_data,
    output cpu_pkg::reg_idx_t dst,
    output cpu_pkg::wb_src_t  wb_src,
    output logic              mem_wr
);
    cpu_pkg::alu_op_t   alu_op_d;
    cpu_pkg::imm_kind_t imm_kind;
    cpu_pkg::branch_t   branch;
    cpu_pkg::wb_src_t   wb_src_d;
    cpu_pkg::dst_kind_t dst_kind;
    logic               mem_wr_d;
    cpu_pkg::word_t     rf_a;
    cpu_pkg::word_t     rf_b;
    cpu_pkg::word_t     a_val;
    cpu_pkg::word_t     b_val;
    cpu_pkg::word_t     a_next;
    cpu_pkg::word_t     b_next;
    cpu_pkg::reg_idx_t  dst_next;

    assign rs = instr[25:21];
    assign rt = instr[20:16];

    control_unit u_control (
        .instr   (instr),
        .alu_op  (alu_op_d),
        .imm_kind(imm_kind),
        .branch  (branch),
        .wb_src  (wb_src_d),
        .dst_kind(dst_kind),
        .mem_wr  (mem_wr_d),
        .rs_used (rs_used),
        .rt_used (rt_used)
    );

    reg_file u_reg_file (
        .clk   (clk),
        .resetn(resetn),
        .ra1   (rs),
        .ra2   (rt),
        .wa    (wb_dst),
        .wd    (wb_data),
        .rd1   (rf_a),
        .rd2   (rf_b)
    );

    function automatic cpu_pkg::word_t fwd_mux(input cpu_pkg::fwd_sel_t sel,
                                               input cpu_pkg::word_t rf_val);
        case (sel)
            cpu_pkg::fwd_ex:  return ex_result;
            cpu_pkg::fwd_mem: return mem_result;
            cpu_pkg::fwd_wb:  return wb_data;
            default:          return rf_val;
        endcase
    endfunction

    always_comb begin
        a_val = fwd_mux(fwd_a, rf_a);
        b_val = fwd_mux(fwd_b, rf_b);
    end

    always_comb begin
        case (imm_kind)
            cpu_pkg::imm_sign:  b_next = {{16{instr[15]}}, instr[15:0]};
            cpu_pkg::imm_zero:  b_next = {16'b0, instr[15:0]};
            cpu_pkg::imm_upper: b_next = {instr[15:0], 16'b0};
            default:            b_next = b_val;
        endcase
        a_next = a_val;
        // jal link value goes through the adder as pc + 8 plus zero
        if (dst_kind == cpu_pkg::dst_ra) begin
            a_next = pc_plus4 + 32'd4;
            b_next = '0;
        end
        case (dst_kind)
            cpu_pkg::dst_rt: dst_next = rt;
            cpu_pkg::dst_rd: dst_next = instr[15:11];
            cpu_pkg::dst_ra: dst_next = cpu_pkg::reg_ra;
            default:         dst_next = '0;
        endcase
    end

    always_comb begin
        branch_taken  = 1'b0;
        branch_target = pc_plus4 + {{14{instr[15]}}, instr[15:0], 2'b00};
        case (branch)
            cpu_pkg::br_beq: branch_taken = (a_val == b_val);
            cpu_pkg::br_bne: branch_taken = (a_val != b_val);
            cpu_pkg::br_j: begin
                branch_taken  = 1'b1;
                branch_target = {pc_plus4[31:28], instr[25:0], 2'b00};
            end
            cpu_pkg::br_jr: begin
                branch_taken  = 1'b1;
                branch_target = a_val;
            end
            default: ;
        endcase
    end

    // ID/EX, load-use inserts a bubble
    always_ff @(posedge clk) begin
        if (!resetn || (load_stall && !pipe_stall)) begin
            dst    <= '0;
            wb_src <= cpu_pkg::wb_alu;
            mem_wr <= 1'b0;
        end else if (!pipe_stall) begin
            dst    <= dst_next;
            wb_src <= wb_src_d;
            mem_wr <= mem_wr_d;
        end
    end

    always_ff @(posedge clk) begin
        if (!pipe_stall) begin
            alu_op     <= alu_op_d;
            op_a       <= a_next;
            op_b       <= b_next;
            shamt      <= instr[10:6];
            store_data <= b_val;
        end
    end

endmodule

/* fetch_stage.sv */
`timescale 1ns/1ps

module fetch_stage (
    input  logic           clk,
    input  logic           resetn,
    input  cpu_pkg::word_t inst_rdata,
    input  logic           inst_ok,
    input  logic           branch_taken,
    input  cpu_pkg::word_t branch_target,
    input  logic           pipe_stall,
    input  logic           load_stall,
    output logic           inst_req,
    output cpu_pkg::word_t inst_addr,
    output cpu_pkg::word_t instr,
    output cpu_pkg::word_t pc_plus4,
    output logic           fetch_wait
);
    cpu_pkg::word_t pc;
    cpu_pkg::word_t hold_instr;
    logic           hold_valid;
    logic           running;
    logic           accepted;
    logic           advance;

    assign inst_req   = running & ~hold_valid;
    assign inst_addr  = pc;
    assign accepted   = inst_req & inst_ok;
    assign fetch_wait = ~hold_valid & ~accepted;
    assign advance    = ~pipe_stall & ~load_stall;

    // branch in decode redirects the fetch after the delay slot
    always_ff @(posedge clk) begin
        if (!resetn) begin
            pc         <= cpu_pkg::reset_pc;
            hold_valid <= 1'b0;
            running    <= 1'b0;
            instr      <= '0;
        end else begin
            running <= 1'b1;
            if (advance) begin
                pc         <= branch_taken ? branch_target : pc + 32'd4;
                hold_valid <= 1'b0;
                instr      <= hold_valid ? hold_instr : inst_rdata;
            end else if (accepted) begin
                hold_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            pc_plus4 <= pc + 32'd4;
        end else if (accepted) begin
            hold_instr <= inst_rdata;
        end
    end

    assert property (@(posedge clk) disable iff (!resetn)
        inst_req |-> inst_addr[1:0] == 2'b00);

endmodule

/* reg_file.sv */
`timescale 1ns/1ps

module reg_file (
    input  logic              clk,
    input  logic              resetn,
    input  cpu_pkg::reg_idx_t ra1,
    input  cpu_pkg::reg_idx_t ra2,
    input  cpu_pkg::reg_idx_t wa,
    input  cpu_pkg::word_t    wd,
    output cpu_pkg::word_t    rd1,
    output cpu_pkg::word_t    rd2
);
    cpu_pkg::word_t regs [0:31];

    // $zero cleared in reset, never written
    always_ff @(posedge clk) begin
        if (!resetn) begin
            regs[0] <= '0;
        end else if (wa != '0) begin
            regs[wa] <= wd;
        end
    end

    assign rd1 = regs[ra1];
    assign rd2 = regs[ra2];

    assert property (@(posedge clk) disable iff (!resetn)
        (ra1 == '0 |-> rd1 == '0) and (ra2 == '0 |-> rd2 == '0));

endmodule

/* control_unit.sv */
`timescale 1ns/1ps

module control_unit (
    input  cpu_pkg::word_t     instr,
    output cpu_pkg::alu_op_t   alu_op,
    output cpu_pkg::imm_kind_t imm_kind,
    output cpu_pkg::branch_t   branch,
    output cpu_pkg::wb_src_t   wb_src,
    output cpu_pkg::dst_kind_t dst_kind,
    output logic               mem_wr,
    output logic               rs_used,
    output logic               rt_used
);
    cpu_pkg::opcode_t opcode;
    cpu_pkg::funct_t  funct;

    assign opcode = cpu_pkg::opcode_t'(instr[31:26]);
    assign funct  = cpu_pkg::funct_t'(instr[5:0]);

    always_comb begin
        alu_op   = cpu_pkg::alu_add;
        imm_kind = cpu_pkg::imm_reg;
        branch   = cpu_pkg::br_none;
        wb_src   = cpu_pkg::wb_alu;
        dst_kind = cpu_pkg::dst_none;
        mem_wr   = 1'b0;
        rs_used  = 1'b0;
        rt_used  = 1'b0;
        case (opcode)
            cpu_pkg::op_special: begin
                dst_kind = cpu_pkg::dst_rd;
                rs_used  = 1'b1;
                rt_used  = 1'b1;
                case (funct)
                    cpu_pkg::fn_addu: alu_op = cpu_pkg::alu_add;
                    cpu_pkg::fn_subu: alu_op = cpu_pkg::alu_sub;
                    cpu_pkg::fn_and:  alu_op = cpu_pkg::alu_and;
                    cpu_pkg::fn_or:   alu_op = cpu_pkg::alu_or;
                    cpu_pkg::fn_xor:  alu_op = cpu_pkg::alu_xor;
                    cpu_pkg::fn_nor:  alu_op = cpu_pkg::alu_nor;
                    cpu_pkg::fn_slt:  alu_op = cpu_pkg::alu_slt;
                    cpu_pkg::fn_sltu: alu_op = cpu_pkg::alu_sltu;
                    cpu_pkg::fn_sll, cpu_pkg::fn_srl, cpu_pkg::fn_sra: begin
                        rs_used = 1'b0;
                        if (funct == cpu_pkg::fn_sll) begin
                            alu_op = cpu_pkg::alu_sll;
                        end else if (funct == cpu_pkg::fn_srl) begin
                            alu_op = cpu_pkg::alu_srl;
                        end else begin
                            alu_op = cpu_pkg::alu_sra;
                        end
                    end
                    cpu_pkg::fn_jr: begin
                        branch   = cpu_pkg::br_jr;
                        dst_kind = cpu_pkg::dst_none;
                        rt_used  = 1'b0;
                    end
                    default: begin
                        dst_kind = cpu_pkg::dst_none;
                        rs_used  = 1'b0;
                        rt_used  = 1'b0;
                    end
                endcase
            end
            cpu_pkg::op_j:   branch = cpu_pkg::br_j;
            cpu_pkg::op_jal: begin
                branch   = cpu_pkg::br_j;
                dst_kind = cpu_pkg::dst_ra;
            end
            cpu_pkg::op_beq, cpu_pkg::op_bne: begin
                branch  = (opcode == cpu_pkg::op_beq) ? cpu_pkg::br_beq : cpu_pkg::br_bne;
                rs_used = 1'b1;
                rt_used = 1'b1;
            end
            cpu_pkg::op_sw: begin
                imm_kind = cpu_pkg::imm_sign;
                mem_wr   = 1'b1;
                rs_used  = 1'b1;
                rt_used  = 1'b1;
            end
            cpu_pkg::op_addiu, cpu_pkg::op_slti, cpu_pkg::op_andi, cpu_pkg::op_ori,
            cpu_pkg::op_xori, cpu_pkg::op_lui, cpu_pkg::op_lw: begin
                dst_kind = cpu_pkg::dst_rt;
                rs_used  = (opcode != cpu_pkg::op_lui);
                imm_kind = cpu_pkg::imm_sign;
                case (opcode)
                    cpu_pkg::op_slti: alu_op = cpu_pkg::alu_slt;
                    cpu_pkg::op_andi: alu_op = cpu_pkg::alu_and;
                    cpu_pkg::op_ori:  alu_op = cpu_pkg::alu_or;
                    cpu_pkg::op_xori: alu_op = cpu_pkg::alu_xor;
                    cpu_pkg::op_lui:  alu_op = cpu_pkg::alu_lui;
                    cpu_pkg::op_lw:   wb_src = cpu_pkg::wb_mem;
                    default: ;
                endcase
                // logical immediates are zero extended
                if (opcode inside {cpu_pkg::op_andi, cpu_pkg::op_ori, cpu_pkg::op_xori}) begin
                    imm_kind = cpu_pkg::imm_zero;
                end else if (opcode == cpu_pkg::op_lui) begin
                    imm_kind = cpu_pkg::imm_upper;
                end
            end
            default: ;
        endcase
    end

endmodule

/* cpu_pkg.sv */
package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    localparam word_t    reset_pc = 32'hbfc0_0000;
    localparam reg_idx_t reg_ra   = 5'd31;

    typedef enum logic [5:0] {
        op_special = 6'h00,
        op_j       = 6'h02,
        op_jal     = 6'h03,
        op_beq     = 6'h04,
        op_bne     = 6'h05,
        op_addiu   = 6'h09,
        op_slti    = 6'h0a,
        op_andi    = 6'h0c,
        op_ori     = 6'h0d,
        op_xori    = 6'h0e,
        op_lui     = 6'h0f,
        op_lw      = 6'h23,
        op_sw      = 6'h2b
    } opcode_t;

    typedef enum logic [5:0] {
        fn_sll  = 6'h00,
        fn_srl  = 6'h02,
        fn_sra  = 6'h03,
        fn_jr   = 6'h08,
        fn_addu = 6'h21,
        fn_subu = 6'h23,
        fn_and  = 6'h24,
        fn_or   = 6'h25,
        fn_xor  = 6'h26,
        fn_nor  = 6'h27,
        fn_slt  = 6'h2a,
        fn_sltu = 6'h2b
    } funct_t;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_nor,
        alu_slt, alu_sltu, alu_sll, alu_srl, alu_sra, alu_lui
    } alu_op_t;

    typedef enum logic [2:0] {br_none, br_beq, br_bne, br_j, br_jr} branch_t;

    typedef enum logic {wb_alu, wb_mem} wb_src_t;

    typedef enum logic [1:0] {fwd_rf, fwd_ex, fwd_mem, fwd_wb} fwd_sel_t;

    // source of operand b
    typedef enum logic [1:0] {imm_reg, imm_sign, imm_zero, imm_upper} imm_kind_t;

    typedef enum logic [1:0] {dst_none, dst_rt, dst_rd, dst_ra} dst_kind_t;

endpackage
